// ==== arcade_settings.svh ====
`ifndef ARCADE_SETTINGS_SVH
`define ARCADE_SETTINGS_SVH

// rom image
`define ROM_AW        8

// download link, credits double as fifo depth
`define DL_CREDITS    4

// tiny raster, columns
`define H_VIS         16
`define H_TOTAL       24
`define H_SYNC_START  18
`define H_SYNC_LEN    3

// lines
`define V_VIS         8
`define V_TOTAL       12
`define V_SYNC_START  9
`define V_SYNC_LEN    1

`endif

// ==== dl_pkg.sv ====
`include "arcade_settings.svh"

package dl_pkg;

	// byte address into the game rom
	typedef logic [`ROM_AW-1:0] rom_addr_t;

	typedef logic [7:0] rom_byte_t;

	// one download write from the host
	typedef struct packed {
		rom_addr_t addr;
		rom_byte_t data;
	} dl_beat_t;

endpackage

// ==== cab_pkg.sv ====
package cab_pkg;

	typedef enum logic [1:0] {
		NAUGHTY_BOY   = 2'd0,
		POP_FLAMER    = 2'd1,
		TRIVIA_MASTER = 2'd2,
		MOD_OTHER     = 2'd3
	} game_mod_t;

	// raw controls of one player
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
		logic start;
	} player_raw_t;

	typedef logic [4:0] game_btns_t;

	// operator menu options
	typedef struct packed {
		logic [1:0] lives;
		logic       difficulty;
		logic [1:0] bonus;
		logic       cabinet; // upright / cocktail
		logic       flip;
		logic       spare;
	} options_t;

	typedef logic [7:0] dip_t;

	typedef struct packed {
		logic [1:0] r;
		logic [1:0] g;
		logic [1:0] b;
	} rgb_t;

	typedef struct packed {
		rgb_t rgb;
		logic hs;
		logic vs;
		logic hblank;
		logic vblank;
	} video_out_t;

endpackage

// ==== rom_loader.sv ====
`timescale 1ns/1ps
`include "arcade_settings.svh"

module rom_loader (
	input  logic               clock_12,
	input  logic               rst_n,
	input  logic               dl_active,
	input  logic               dl_valid,
	input  dl_pkg::dl_beat_t   dl_beat,
	output logic               dl_credit,
	input  logic               rom_free,
	input  dl_pkg::rom_addr_t  rd_addr,
	output dl_pkg::rom_byte_t  rd_data,
	input  logic               options_rst,
	output logic               rom_loaded,
	output logic               core_rst_n
);

	localparam int DEPTH = `DL_CREDITS;
	localparam int PW    = $clog2(DEPTH);

	dl_pkg::dl_beat_t  fifo_mem [DEPTH];
	dl_pkg::rom_byte_t rom_mem [2**`ROM_AW];

	logic [PW-1:0]    wr_ptr;
	logic [PW-1:0]    rd_ptr;
	logic [PW:0]      count;
	logic             push;
	logic             pop;
	logic             empty;
	logic             dl_active_q;
	logic             dl_done;
	dl_pkg::dl_beat_t head;

	assign empty     = (count == '0);
	assign push      = dl_valid; // host owns the credit check
	assign pop       = rom_free && !empty; // drain only outside visible area
	assign head      = fifo_mem[rd_ptr];
	assign dl_credit = pop;

	always_ff @(posedge clock_12) begin
		if (push)
			fifo_mem[wr_ptr] <= dl_beat;
		if (pop)
			rom_mem[head.addr] <= head.data;
		rd_data <= rom_mem[rd_addr];
	end

	always_ff @(posedge clock_12) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// end of image is the falling edge of dl_active, then wait for the fifo
	always_ff @(posedge clock_12) begin
		if (!rst_n) begin
			dl_active_q <= 1'b0;
			dl_done     <= 1'b0;
			rom_loaded  <= 1'b0;
			core_rst_n  <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			if (dl_active_q && !dl_active)
				dl_done <= 1'b1;
			if ((dl_done || (dl_active_q && !dl_active)) && empty)
				rom_loaded <= 1'b1; // sticky until rst_n
			core_rst_n <= rom_loaded && !options_rst;
		end
	end

	// host must have been out of credits here
	a_no_overflow: assert property (@(posedge clock_12) disable iff (!rst_n)
		dl_valid |-> (count < (PW + 1)'(DEPTH)));

endmodule

// ==== cabinet_inputs.sv ====
`timescale 1ns/1ps

module cabinet_inputs (
	input  logic                clock_12,
	input  logic                rst_n,
	input  cab_pkg::game_mod_t  game_mod,
	input  cab_pkg::options_t   options,
	input  cab_pkg::player_raw_t p1,
	input  cab_pkg::player_raw_t p2,
	input  logic                coin,
	output cab_pkg::game_btns_t btn1,
	output cab_pkg::game_btns_t btn2,
	output logic [1:0]          starts,
	output logic                coin_out,
	output cab_pkg::dip_t       dip
);

	// per-variant button wiring
	function automatic cab_pkg::game_btns_t map_btns(input cab_pkg::game_mod_t mode,
			input cab_pkg::player_raw_t p);
		cab_pkg::game_btns_t b;
		case (mode)
			cab_pkg::TRIVIA_MASTER:
				b = {p.fire_d, p.fire_c, p.fire_b, p.fire_a, 1'b0}; // four answer buttons
			default:
				b = {p.left, p.right, p.down, p.up, p.fire_a}; // joystick variants
		endcase
		return b;
	endfunction

	cab_pkg::dip_t dip_nxt;

	// bits 5:4 are fixed on the board
	assign dip_nxt = {options.difficulty, options.cabinet, 1'b0, 1'b1,
		options.bonus, options.lives};

	always_ff @(posedge clock_12) begin
		if (!rst_n) begin
			btn1     <= '0;
			btn2     <= '0;
			starts   <= '0;
			coin_out <= 1'b0;
			dip      <= '0;
		end else begin
			btn1     <= map_btns(game_mod, p1);
			btn2     <= map_btns(game_mod, p2);
			starts   <= {p2.start, p1.start};
			coin_out <= coin;
			dip      <= dip_nxt;
		end
	end

endmodule

// ==== video_gen.sv ====
`timescale 1ns/1ps
`include "arcade_settings.svh"

module video_gen (
	input  logic                clock_12,
	input  logic                rst_n,
	input  logic                rom_loaded,
	output dl_pkg::rom_addr_t   rd_addr,
	input  dl_pkg::rom_byte_t   rd_data,
	output logic                rom_free,
	input  logic                flip,
	output cab_pkg::video_out_t video
);

	localparam int HW = $clog2(`H_TOTAL);
	localparam int VW = $clog2(`V_TOTAL);

	typedef enum logic [1:0] {ACTIVE, H_BLANK, V_BLANK} vid_state_t;

	vid_state_t        state, state_nxt;
	logic [HW-1:0]     h_cnt, h_nxt;
	logic [VW-1:0]     v_cnt, v_nxt;
	logic              hb, vb, hs, vs;
	logic              hb_d1, vb_d1, hs_d1, vs_d1;
	dl_pkg::rom_addr_t lin_addr;
	cab_pkg::rgb_t     pixel;

	always_comb begin
		h_nxt = h_cnt + 1'b1;
		v_nxt = v_cnt;
		if (h_cnt == HW'(`H_TOTAL - 1)) begin
			h_nxt = '0;
			v_nxt = (v_cnt == VW'(`V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
		end
	end

	// state tracks the position the counters move to
	always_comb begin
		if (v_nxt >= VW'(`V_VIS))
			state_nxt = V_BLANK;
		else if (h_nxt >= HW'(`H_VIS))
			state_nxt = H_BLANK;
		else
			state_nxt = ACTIVE;
	end

	always_ff @(posedge clock_12) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
			state <= ACTIVE;
		end else begin
			h_cnt <= h_nxt;
			v_cnt <= v_nxt;
			state <= state_nxt;
		end
	end

	assign rom_free = (state != ACTIVE);
	assign hb = (h_cnt >= HW'(`H_VIS));
	assign vb = (v_cnt >= VW'(`V_VIS));
	assign hs = (h_cnt >= HW'(`H_SYNC_START)) && (h_cnt < HW'(`H_SYNC_START + `H_SYNC_LEN));
	assign vs = (v_cnt >= VW'(`V_SYNC_START)) && (v_cnt < VW'(`V_SYNC_START + `V_SYNC_LEN));

	assign lin_addr = dl_pkg::rom_addr_t'(v_cnt * `H_VIS + h_cnt); // row*16 + col
	assign rd_addr  = flip ? ~lin_addr : lin_addr; // 255 - addr
	assign pixel    = (hb_d1 || vb_d1 || !rom_loaded) ? '0 : cab_pkg::rgb_t'(rd_data[5:0]);

	// stage 1 waits for rom data, stage 2 is the output register
	always_ff @(posedge clock_12) begin
		if (!rst_n) begin
			hb_d1 <= 1'b0;
			vb_d1 <= 1'b0;
			hs_d1 <= 1'b0;
			vs_d1 <= 1'b0;
			video <= '0;
		end else begin
			hb_d1 <= hb;
			vb_d1 <= vb;
			hs_d1 <= hs;
			vs_d1 <= vs;
			video <= '{rgb: pixel, hs: hs_d1, vs: vs_d1, hblank: hb_d1, vblank: vb_d1};
		end
	end

	// rom writes must land where the screen shows blank
	a_free_in_blank: assert property (@(posedge clock_12) disable iff (!rst_n)
		rom_free |-> ##2 (video.hblank || video.vblank));

endmodule

// ==== arcade_shell.sv ====
`timescale 1ns/1ps

module arcade_shell (
	input  logic                 clock_12,
	input  logic                 rst_n,
	input  logic                 dl_active,
	input  logic                 dl_valid,
	input  dl_pkg::dl_beat_t     dl_beat,
	output logic                 dl_credit,
	input  cab_pkg::game_mod_t   game_mod,
	input  cab_pkg::options_t    options,
	input  logic                 options_rst,
	input  cab_pkg::player_raw_t p1,
	input  cab_pkg::player_raw_t p2,
	input  logic                 coin,
	output cab_pkg::game_btns_t  btn1,
	output cab_pkg::game_btns_t  btn2,
	output logic [1:0]           starts,
	output logic                 coin_out,
	output cab_pkg::dip_t        dip,
	output logic                 rom_loaded,
	output logic                 core_rst_n,
	output cab_pkg::video_out_t  video
);

	// rom read port shared with the raster
	dl_pkg::rom_addr_t rd_addr;
	dl_pkg::rom_byte_t rd_data;
	logic              rom_free;

	rom_loader loader (
		.clock_12    (clock_12),
		.rst_n       (rst_n),
		.dl_active   (dl_active),
		.dl_valid    (dl_valid),
		.dl_beat     (dl_beat),
		.dl_credit   (dl_credit),
		.rom_free    (rom_free),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.options_rst (options_rst),
		.rom_loaded  (rom_loaded),
		.core_rst_n  (core_rst_n)
	);

	cabinet_inputs inputs (
		.clock_12 (clock_12),
		.rst_n    (rst_n),
		.game_mod (game_mod),
		.options  (options),
		.p1       (p1),
		.p2       (p2),
		.coin     (coin),
		.btn1     (btn1),
		.btn2     (btn2),
		.starts   (starts),
		.coin_out (coin_out),
		.dip      (dip)
	);

	video_gen video_inst (
		.clock_12   (clock_12),
		.rst_n      (rst_n),
		.rom_loaded (rom_loaded),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.rom_free   (rom_free),
		.flip       (options.flip),
		.video      (video)
	);

endmodule

// ==== tb_arcade_shell.sv ====
`timescale 1ns/1ps
`include "arcade_settings.svh"

module tb_arcade_shell;

	localparam int FRAME = `H_TOTAL * `V_TOTAL;

	logic                 clock_12;
	logic                 rst_n;
	logic                 dl_active;
	logic                 dl_valid;
	dl_pkg::dl_beat_t     dl_beat;
	logic                 dl_credit;
	cab_pkg::game_mod_t   game_mod;
	cab_pkg::options_t    options;
	logic                 options_rst;
	cab_pkg::player_raw_t p1;
	cab_pkg::player_raw_t p2;
	logic                 coin;
	cab_pkg::game_btns_t  btn1;
	cab_pkg::game_btns_t  btn2;
	logic [1:0]           starts;
	logic                 coin_out;
	cab_pkg::dip_t        dip;
	logic                 rom_loaded;
	logic                 core_rst_n;
	cab_pkg::video_out_t  video;

	string      recs [$]; // golden records in file order
	logic [7:0] rom_model [256];
	bit         known [256]; // bytes the download has written
	integer     seed;
	int         cyc; // rising edges since reset release
	int         credits;
	int         sent;
	int         returned;
	int         errors;
	int         tests;
	int         sum_row;
	int         row_sum;
	logic [1:0] credit_hist;
	logic       loaded_q;
	bit         running;
	bit         in_download;
	bit         pix_en;

	arcade_shell UUT (
		.clock_12(clock_12), .rst_n(rst_n), .dl_active(dl_active), .dl_valid(dl_valid),
		.dl_beat(dl_beat), .dl_credit(dl_credit), .game_mod(game_mod), .options(options),
		.options_rst(options_rst), .p1(p1), .p2(p2), .coin(coin), .btn1(btn1), .btn2(btn2),
		.starts(starts), .coin_out(coin_out), .dip(dip), .rom_loaded(rom_loaded),
		.core_rst_n(core_rst_n), .video(video)
	);

	initial begin
		clock_12 = 1'b0;
		forever #50 clock_12 = ~clock_12;
	end

	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$finish;
	endtask

	task automatic close_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - errs_before);
	endtask

	// one clock, outputs sampled mid-cycle, credits and video checked here
	task automatic tick();
		int         pos;
		int         col;
		int         row;
		logic [7:0] addr8;
		logic [5:0] got;
		@(negedge clock_12);
		if (running) begin
			cyc++;
			if (credit_hist[0]) begin // usable once its pulse cycle has ended
				credits++;
				returned++;
			end
			assert (credits <= `DL_CREDITS) else begin
				$display("t=%0t a credit came back with no byte outstanding", $time);
				errors++;
			end
			if (in_download)
				expect_eq("core_rst_n", 32'(core_rst_n), 32'd0);
			if (cyc >= 2) begin
				pos = (cyc - 2) % FRAME; // video lags the raster by two
				col = pos % `H_TOTAL;
				row = pos / `H_TOTAL;
				got = video.rgb;
				expect_eq("hblank", 32'(video.hblank), 32'(col >= `H_VIS));
				expect_eq("vblank", 32'(video.vblank), 32'(row >= `V_VIS));
				expect_eq("hs", 32'(video.hs),
					32'(col >= `H_SYNC_START && col < `H_SYNC_START + `H_SYNC_LEN));
				expect_eq("vs", 32'(video.vs),
					32'(row >= `V_SYNC_START && row < `V_SYNC_START + `V_SYNC_LEN));
				assert (!(video.hs || video.vs) || video.hblank || video.vblank) else begin
					$display("t=%0t sync pulse outside blanking", $time);
					errors++;
				end
				assert (!credit_hist[1] || video.hblank || video.vblank) else begin
					$display("t=%0t credit returned during a visible pixel", $time);
					errors++;
				end
				if (video.hblank || video.vblank || !loaded_q)
					expect_eq("rgb", 32'(got), 32'd0);
				else if (pix_en) begin
					addr8 = 8'(row * `H_VIS + col);
					if (options.flip)
						addr8 = 8'(255 - (row * `H_VIS + col));
					if (known[addr8]) begin
						expect_eq("rgb", 32'(got), 32'(rom_model[addr8][5:0]));
						if (row == sum_row)
							row_sum += int'(got);
					end
				end
			end
			credit_hist = {credit_hist[0], dl_credit};
			loaded_q = rom_loaded;
		end
	endtask

	task automatic wait_credit();
		int n;
		n = 0;
		while (credits == 0) begin
			tick();
			n++;
			if (n > 2 * FRAME)
				abort_run("timeout while waiting for a download credit");
		end
	endtask

	// one frame from its first pixel, summing the chosen row
	task automatic run_frame(input int row, input int exp_sum);
		int n;
		repeat (4) tick(); // flip settles through the read pipeline
		n = 0;
		while ((cyc - 1) % FRAME != 0) begin
			tick();
			n++;
			if (n > 2 * FRAME)
				abort_run("timeout while waiting for the start of a frame");
		end
		row_sum = 0;
		sum_row = row;
		pix_en = 1'b1;
		repeat (FRAME) tick();
		pix_en = 1'b0;
		expect_eq("row_sum", 32'(row_sum), 32'(exp_sum));
	endtask

	initial begin
		int    fd;
		int    n;
		int    e0;
		int    gap;
		int    a;
		int    d;
		int    m;
		int    o;
		int    q1;
		int    q2;
		int    b1;
		int    b2;
		int    dp;
		string line;
		rst_n = 1'b0;
		dl_active = 1'b0;
		dl_valid = 1'b0;
		dl_beat = '0;
		game_mod = cab_pkg::MOD_OTHER;
		options = '0;
		options_rst = 1'b0;
		p1 = '0;
		p2 = '0;
		coin = 1'b0;
		seed = 32'hbd5f5007;
		{cyc, credits, sent, returned, errors, tests, row_sum} = '0;
		credits = `DL_CREDITS;
		sum_row = -1;
		credit_hist = 2'b00;
		loaded_q = 1'b0;
		{running, in_download, pix_en} = 3'b000;
		fd = $fopen("arcade_golden.txt", "r");
		if (fd == 0)
			abort_run("cannot open arcade_golden.txt");
		else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#")
					recs.push_back(line);
			end
			$fclose(fd);
		end

		repeat (4) tick();
		rst_n = 1'b1;
		running = 1'b1;
		tick();
		e0 = errors;
		expect_eq("core_rst_n", 32'(core_rst_n), 32'd0);
		expect_eq("rom_loaded", 32'(rom_loaded), 32'd0);
		expect_eq("dl_credit", 32'(dl_credit), 32'd0);
		expect_eq("video", 32'(video), 32'd0);
		close_test("reset state", e0);

		e0 = errors;
		in_download = 1'b1;
		dl_active = 1'b1;
		foreach (recs[k]) begin
			if (recs[k].getc(0) != "D")
				continue;
			if ($sscanf(recs[k], "D %h %h", a, d) != 2)
				abort_run("malformed download record in the golden file");
			wait_credit();
			dl_valid = 1'b1;
			dl_beat.addr = a[7:0];
			dl_beat.data = d[7:0];
			credits--;
			sent++;
			rom_model[a[7:0]] = d[7:0];
			known[a[7:0]] = 1'b1;
			tick();
			dl_valid = 1'b0;
			gap = $unsigned($random(seed)) % 4;
			repeat (gap) tick();
		end
		dl_active = 1'b0;
		n = 0;
		while (!rom_loaded) begin
			tick();
			n++;
			if (n > 4 * FRAME)
				abort_run("timeout while waiting for rom_loaded");
		end
		in_download = 1'b0;
		expect_eq("credits", 32'(credits), 32'(`DL_CREDITS));
		expect_eq("returned", 32'(returned), 32'(sent));
		close_test("download credits", e0);

		e0 = errors;
		expect_eq("core_rst_n", 32'(core_rst_n), 32'd0);
		tick();
		expect_eq("core_rst_n", 32'(core_rst_n), 32'd1);
		options_rst = 1'b1;
		tick();
		expect_eq("core_rst_n", 32'(core_rst_n), 32'd0);
		options_rst = 1'b0;
		tick();
		expect_eq("core_rst_n", 32'(core_rst_n), 32'd1);
		close_test("load and core reset", e0);

		e0 = errors;
		foreach (recs[k]) begin
			if (recs[k].getc(0) != "I")
				continue;
			if ($sscanf(recs[k], "I %h %h %h %h %h %h %h", m, o, q1, q2, b1, b2, dp) != 7)
				abort_run("malformed input record in the golden file");
			game_mod = cab_pkg::game_mod_t'(m[1:0]);
			options = cab_pkg::options_t'(o[7:0]);
			p1 = cab_pkg::player_raw_t'(q1[8:0]);
			p2 = cab_pkg::player_raw_t'(q2[8:0]);
			coin = ~coin; // both levels over the records
			tick();
			expect_eq("btn1", 32'(btn1), 32'(b1));
			expect_eq("btn2", 32'(btn2), 32'(b2));
			expect_eq("dip", 32'(dip), 32'(dp));
			expect_eq("starts", 32'(starts), 32'({q2[0], q1[0]}));
			expect_eq("coin_out", 32'(coin_out), 32'(coin));
		end
		close_test("cabinet inputs", e0);

		e0 = errors;
		foreach (recs[k]) begin
			if (recs[k].getc(0) != "R")
				continue;
			if ($sscanf(recs[k], "R %h %h %h", a, m, d) != 3)
				abort_run("malformed row record in the golden file");
			options = '0;
			options.flip = a[0];
			run_frame(m, d);
		end
		close_test("video pixels", e0);

		$display("%0d tests run, %0d checks failed", tests, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== arcade_golden.txt ====
# D addr data | I game_mod options p1 p2 btn1 btn2 dip | R flip row rgb_sum
# all fields hex, download bytes go out in file order
D 00 01
D 01 c2
D 02 13
D 03 24
D 04 35
D 05 46
D 06 57
D 07 68
D 08 79
D 09 8a
D 0a 9b
D 0b ac
D 0c bd
D 0d ce
D 0e df
D 0f ff
D f0 2a
D ff 15
D 8f 3c
I 0 00 100 010 02 01 10
I 1 e0 060 081 18 04 93
I 2 15 10a 014 14 0a 58
I 3 ff 1ff 000 1f 00 df
I 2 48 1ff 0f0 1e 02 15
R 0 0 1e7
R 1 0 3f
R 1 7 3c

// ==== verilog.f ====
+incdir+.
dl_pkg.sv
cab_pkg.sv
rom_loader.sv
cabinet_inputs.sv
video_gen.sv
arcade_shell.sv
tb_arcade_shell.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_arcade_shell -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
